// File: verilog/gamePkg.sv
package gamePkg;

   // Integer pixel part of a coordinate, signed
   localparam int coordBits = 11;
   // Sub-pixel part, positions are kept in 1/16 pixel
   localparam int fracBits = 4;
   // Speed in 1/16 pixel per frame, unsigned
   localparam int speedBits = 10;

   // One bit per pad key
   typedef struct packed {
      logic up;
      logic down;
      logic right;
      logic left;
   } padKeys_t;

   // Integer screen position of a player
   typedef struct packed {
      logic signed [coordBits-1:0] x;
      logic signed [coordBits-1:0] y;
   } position_t;

   // Direction of the move in progress
   typedef enum logic [2:0] {
      dirNone,
      dirUp,
      dirDown,
      dirRight,
      dirLeft
   } moveDir_t;

   // Player motion FSM states
   typedef enum logic {
      waiting,
      moving
   } motionState_t;

   // Sprite numbers, two animation frames per side
   typedef enum logic [2:0] {
      spriteFace   = 3'd0,
      spriteUp1    = 3'd1,
      spriteUp2    = 3'd2,
      spriteRight1 = 3'd3,
      spriteRight2 = 3'd4,
      spriteLeft1  = 3'd5,
      spriteLeft2  = 3'd6
   } sprite_t;

   // What the renderer needs for one player
   typedef struct packed {
      position_t pos;
      sprite_t   sprite;
   } playerView_t;

   // Start tiles of both players
   localparam position_t player1Start = '{x: 11'sd128, y: 11'sd128};
   localparam position_t player2Start = '{x: 11'sd448, y: 11'sd448};

   // Speeds after reset
   localparam logic [speedBits-1:0] speed1Reset = 10'd16;
   localparam logic [speedBits-1:0] speed2Reset = 10'd3;

   // Wishbone word addresses
   typedef enum logic [2:0] {
      addrSpeed1 = 3'd0,
      addrSpeed2 = 3'd1,
      addrPos1   = 3'd2,
      addrPos2   = 3'd3,
      addrFrames = 3'd4
   } regAddr_t;

endpackage

// File: verilog/videoPkg.sv
package videoPkg;

   // Width of the pixel and line counters
   localparam int timingBits = 12;

   // Frame strobes, each high for one clock
   typedef struct packed {
      logic sof;
      logic eof;
   } frameSync_t;

endpackage

// File: verilog/frameTimer.sv
`timescale 1ns/1ps

module frameTimer
#(
   parameter int lineLength = 800,
   parameter int frameLines = 525
)
(
   input  logic                 clk,
   input  logic                 reset_n,
   output videoPkg::frameSync_t frameSync
);

   localparam int cntBits = videoPkg::timingBits;
   // Last pixel of a line and last line of a frame
   localparam logic [cntBits-1:0] lastPixel = cntBits'(lineLength - 1);
   localparam logic [cntBits-1:0] lastLine = cntBits'(frameLines - 1);

   logic [cntBits-1:0] pixel;
   logic [cntBits-1:0] line;
   logic [cntBits-1:0] pixelNext;
   logic [cntBits-1:0] lineNext;

   // Counter advance, line moves on at the end of each line
   always_comb
   begin
      pixelNext = pixel + 1'b1;
      lineNext = line;
      if (pixel == lastPixel)
      begin
         pixelNext = '0;
         lineNext = (line == lastLine) ? '0 : line + 1'b1;
      end
   end

   // Strobes are decoded from the next count so they line up with the counters
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         pixel <= '0;
         line <= '0;
         frameSync <= '0;
      end
      else
      begin
         pixel <= pixelNext;
         line <= lineNext;
         // Start of frame on the top left pixel
         frameSync.sof <= (pixelNext == '0) && (lineNext == '0);
         // End of frame on the last pixel of the last line
         frameSync.eof <= (pixelNext == lastPixel) && (lineNext == lastLine);
      end
   end

   // Both strobes at once would mean a one-pixel frame
   sofEofApart: assert property (@(posedge clk) disable iff (!reset_n)
      !(frameSync.sof && frameSync.eof));

endmodule

// File: verilog/playerMotion.sv
`timescale 1ns/1ps

module playerMotion
#(
   parameter int                  tileSize = 32,
   parameter gamePkg::position_t  startPos = gamePkg::player1Start
)
(
   input  logic                             clk,
   input  logic                             reset_n,
   input  logic                             step,
   input  gamePkg::padKeys_t                keys,
   input  logic [gamePkg::speedBits-1:0]    speed,
   output logic                             stepDone,
   output gamePkg::position_t               pos,
   output gamePkg::moveDir_t                dir,
   output logic                             moving
);

   // Fixed point: integer pixels above, 1/16 pixel below
   localparam int posBits = gamePkg::coordBits + gamePkg::fracBits;
   localparam int fracBits = gamePkg::fracBits;

   typedef logic signed [posBits-1:0] fixed_t;

   // One tile in sub-pixel units
   localparam fixed_t tileStep = fixed_t'(tileSize << fracBits);

   gamePkg::motionState_t state;
   gamePkg::moveDir_t     startDir;
   gamePkg::moveDir_t     curDir;

   fixed_t posX;
   fixed_t posY;
   fixed_t goalX;
   fixed_t goalY;
   fixed_t velX;
   fixed_t velY;
   fixed_t speedFix;
   fixed_t startGoalX;
   fixed_t startGoalY;
   fixed_t startVelX;
   fixed_t startVelY;
   fixed_t curGoalX;
   fixed_t curGoalY;
   fixed_t curVelX;
   fixed_t curVelY;
   fixed_t nextX;
   fixed_t nextY;
   fixed_t remX;
   fixed_t remY;

   logic startMove;
   logic curMoving;
   logic arriveX;
   logic arriveY;

   // Speed widened to the position format, never negative
   assign speedFix = fixed_t'(speed);

   // New move from the pad, up wins over down, right, left
   always_comb
   begin
      startMove = 1'b0;
      startDir = gamePkg::dirNone;
      startGoalX = posX;
      startGoalY = posY;
      startVelX = '0;
      startVelY = '0;
      if (state == gamePkg::waiting)
      begin
         if (keys.up)
         begin
            startMove = 1'b1;
            startDir = gamePkg::dirUp;
            startGoalY = posY - tileStep;
            startVelY = -speedFix;
         end
         else if (keys.down)
         begin
            startMove = 1'b1;
            startDir = gamePkg::dirDown;
            startGoalY = posY + tileStep;
            startVelY = speedFix;
         end
         else if (keys.right)
         begin
            startMove = 1'b1;
            startDir = gamePkg::dirRight;
            startGoalX = posX + tileStep;
            startVelX = speedFix;
         end
         else if (keys.left)
         begin
            startMove = 1'b1;
            startDir = gamePkg::dirLeft;
            startGoalX = posX - tileStep;
            startVelX = -speedFix;
         end
      end
   end

   // A move that starts on this step also advances on it
   assign curMoving = (state == gamePkg::moving) || startMove;
   assign curDir = (state == gamePkg::moving) ? dir : startDir;
   assign curGoalX = (state == gamePkg::moving) ? goalX : startGoalX;
   assign curGoalY = (state == gamePkg::moving) ? goalY : startGoalY;
   assign curVelX = (state == gamePkg::moving) ? velX : startVelX;
   assign curVelY = (state == gamePkg::moving) ? velY : startVelY;

   assign nextX = posX + curVelX;
   assign nextY = posY + curVelY;

   // Distance left after this step, modular so wrap around is harmless
   assign remX = curGoalX - nextX;
   assign remY = curGoalY - nextY;

   // Goal reached or passed on each axis, an idle axis always counts
   assign arriveX = (curVelX == 0) || ((curVelX > 0) ? (remX <= 0) : (remX >= 0));
   assign arriveY = (curVelY == 0) || ((curVelY > 0) ? (remY <= 0) : (remY >= 0));

   // Goal and velocity, captured when a move starts
   always_ff @(posedge clk)
   begin
      if (step && startMove)
      begin
         goalX <= startGoalX;
         goalY <= startGoalY;
         velX <= startVelX;
         velY <= startVelY;
      end
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         state <= gamePkg::waiting;
         posX <= {startPos.x, {fracBits{1'b0}}};
         posY <= {startPos.y, {fracBits{1'b0}}};
         dir <= gamePkg::dirNone;
         stepDone <= 1'b0;
      end
      else
      begin
         // Answer every step one clock later
         stepDone <= step;
         if (step && curMoving)
         begin
            if (arriveX && arriveY)
            begin
               // Snap onto the tile and wait for keys again
               posX <= curGoalX;
               posY <= curGoalY;
               state <= gamePkg::waiting;
               dir <= gamePkg::dirNone;
            end
            else
            begin
               posX <= nextX;
               posY <= nextY;
               state <= gamePkg::moving;
               dir <= curDir;
            end
         end
      end
   end

   // Sub-pixel bits stay inside
   assign pos = '{x: posX[posBits-1:fracBits], y: posY[posBits-1:fracBits]};
   assign moving = (state == gamePkg::moving);

   // The sequencer waits for each answer before the next step
   noStepWhileDone: assert property (@(posedge clk) disable iff (!reset_n)
      stepDone |-> !step);
   singleDone: assert property (@(posedge clk) disable iff (!reset_n)
      stepDone |=> !stepDone);

endmodule

// File: verilog/spriteAnimator.sv
`timescale 1ns/1ps

module spriteAnimator
(
   input  logic              clk,
   input  logic              reset_n,
   input  logic              update,
   input  gamePkg::moveDir_t dir,
   input  logic              moving,
   output gamePkg::sprite_t  sprite
);

   logic             phase;
   logic             nextPhase;
   gamePkg::sprite_t chosen;

   // Walk cycle alternates each frame in motion, restarts when standing
   assign nextPhase = moving ? ~phase : 1'b0;

   // Frame 1 on a set phase, frame 2 otherwise
   always_comb
   begin
      chosen = gamePkg::spriteFace;
      if (moving)
      begin
         case (dir)
            gamePkg::dirUp: chosen = nextPhase ? gamePkg::spriteUp1 : gamePkg::spriteUp2;
            gamePkg::dirRight:
               chosen = nextPhase ? gamePkg::spriteRight1 : gamePkg::spriteRight2;
            gamePkg::dirLeft:
               chosen = nextPhase ? gamePkg::spriteLeft1 : gamePkg::spriteLeft2;
            // Walking down shows the face
            default: chosen = gamePkg::spriteFace;
         endcase
      end
   end

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         phase <= 1'b0;
         sprite <= gamePkg::spriteFace;
      end
      else if (update)
      begin
         phase <= nextPhase;
         sprite <= chosen;
      end
   end

endmodule

// File: verilog/gameController.sv
`timescale 1ns/1ps

module gameController
#(
   parameter int tileSize = 32
)
(
   input  logic                          clk,
   input  logic                          reset_n,
   input  videoPkg::frameSync_t          frameSync,
   input  gamePkg::padKeys_t             pad1,
   input  gamePkg::padKeys_t             pad2,
   input  logic [gamePkg::speedBits-1:0] speed1,
   input  logic [gamePkg::speedBits-1:0] speed2,
   output gamePkg::playerView_t          view1,
   output gamePkg::playerView_t          view2
);

   // Frame sequencer states
   typedef enum logic [2:0] {
      idle,
      stepOne,
      waitOne,
      stepTwo,
      waitTwo
   } seqState_t;

   seqState_t state;

   logic step1;
   logic step2;
   logic stepDone1;
   logic stepDone2;
   logic moving1;
   logic moving2;

   gamePkg::position_t pos1;
   gamePkg::position_t pos2;
   gamePkg::moveDir_t  dir1;
   gamePkg::moveDir_t  dir2;
   gamePkg::sprite_t   sprite1;
   gamePkg::sprite_t   sprite2;

   // Player 1 first, then player 2, once per frame after eof
   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
         state <= idle;
      else
      begin
         case (state)
            idle: if (frameSync.eof) state <= stepOne;
            stepOne: state <= waitOne;
            waitOne: if (stepDone1) state <= stepTwo;
            stepTwo: state <= waitTwo;
            waitTwo: if (stepDone2) state <= idle;
            default: state <= idle;
         endcase
      end
   end

   // Step pulses straight from the state
   assign step1 = (state == stepOne);
   assign step2 = (state == stepTwo);

   playerMotion #(.tileSize(tileSize), .startPos(gamePkg::player1Start)) motion1
   (
      .clk(clk), .reset_n(reset_n), .step(step1), .keys(pad1), .speed(speed1),
      .stepDone(stepDone1), .pos(pos1), .dir(dir1), .moving(moving1)
   );

   playerMotion #(.tileSize(tileSize), .startPos(gamePkg::player2Start)) motion2
   (
      .clk(clk), .reset_n(reset_n), .step(step2), .keys(pad2), .speed(speed2),
      .stepDone(stepDone2), .pos(pos2), .dir(dir2), .moving(moving2)
   );

   // Animators tick once per finished step
   spriteAnimator anim1
   (
      .clk(clk), .reset_n(reset_n), .update(stepDone1), .dir(dir1), .moving(moving1),
      .sprite(sprite1)
   );

   spriteAnimator anim2
   (
      .clk(clk), .reset_n(reset_n), .update(stepDone2), .dir(dir2), .moving(moving2),
      .sprite(sprite2)
   );

   assign view1 = '{pos: pos1, sprite: sprite1};
   assign view2 = '{pos: pos2, sprite: sprite2};

endmodule

// File: verilog/gameRegs.sv
`timescale 1ns/1ps

module gameRegs
(
   input  logic                          clk,
   input  logic                          reset_n,
   input  logic                          wbCyc,
   input  logic                          wbStb,
   input  logic                          wbWe,
   input  logic [2:0]                    wbAdr,
   input  logic [31:0]                   wbDatW,
   input  videoPkg::frameSync_t          frameSync,
   input  gamePkg::playerView_t          view1,
   input  gamePkg::playerView_t          view2,
   output logic [31:0]                   wbDatR,
   output logic                          wbAck,
   output logic [gamePkg::speedBits-1:0] speed1,
   output logic [gamePkg::speedBits-1:0] speed2
);

   localparam int speedBits = gamePkg::speedBits;

   gamePkg::regAddr_t addr;

   logic [31:0] frameCount;
   logic        writeNow;

   // Zero speed would freeze a player mid move
   function automatic logic [speedBits-1:0] clampSpeed(input logic [31:0] data);
      logic [speedBits-1:0] raw;
      raw = data[speedBits-1:0];
      return (raw == '0) ? speedBits'(1) : raw;
   endfunction

   // x in the upper half, y in the lower half, both sign extended
   function automatic logic [31:0] packPos(input gamePkg::position_t p);
      return {16'(p.x), 16'(p.y)};
   endfunction

   assign addr = gamePkg::regAddr_t'(wbAdr);

   // Write lands on the ack cycle
   assign writeNow = wbAck && wbCyc && wbStb && wbWe;

   always_ff @(posedge clk or negedge reset_n)
   begin
      if (!reset_n)
      begin
         wbAck <= 1'b0;
         speed1 <= gamePkg::speed1Reset;
         speed2 <= gamePkg::speed2Reset;
         frameCount <= '0;
      end
      else
      begin
         // Single cycle ack, one clock after the request
         wbAck <= wbCyc && wbStb && !wbAck;
         if (frameSync.eof)
            frameCount <= frameCount + 1'b1;
         if (writeNow)
         begin
            // Positions and frame count are read only
            case (addr)
               gamePkg::addrSpeed1: speed1 <= clampSpeed(wbDatW);
               gamePkg::addrSpeed2: speed2 <= clampSpeed(wbDatW);
               default: ;
            endcase
         end
      end
   end

   // Read mux, valid while ack is high
   always_comb
   begin
      case (addr)
         gamePkg::addrSpeed1: wbDatR = 32'(speed1);
         gamePkg::addrSpeed2: wbDatR = 32'(speed2);
         gamePkg::addrPos1: wbDatR = packPos(view1.pos);
         gamePkg::addrPos2: wbDatR = packPos(view2.pos);
         gamePkg::addrFrames: wbDatR = frameCount;
         default: wbDatR = '0;
      endcase
   end

   // Master must hold the request until it sees the ack
   ackInCycle: assert property (@(posedge clk) disable iff (!reset_n)
      wbAck |-> (wbCyc && wbStb));

endmodule

// File: verilog/gameTop.sv
`timescale 1ns/1ps

module gameTop
#(
   parameter int tileSize = 32,
   parameter int lineLength = 800,
   parameter int frameLines = 525
)
(
   input  logic                 clk,
   input  logic                 reset_n,
   input  gamePkg::padKeys_t    pad1,
   input  gamePkg::padKeys_t    pad2,
   input  logic                 wbCyc,
   input  logic                 wbStb,
   input  logic                 wbWe,
   input  logic [2:0]           wbAdr,
   input  logic [31:0]          wbDatW,
   output logic [31:0]          wbDatR,
   output logic                 wbAck,
   output gamePkg::playerView_t view1,
   output gamePkg::playerView_t view2,
   output videoPkg::frameSync_t frameSync
);

   logic [gamePkg::speedBits-1:0] speed1;
   logic [gamePkg::speedBits-1:0] speed2;

   // Frame strobes pace the whole game
   frameTimer #(.lineLength(lineLength), .frameLines(frameLines)) timer
   (
      .clk(clk), .reset_n(reset_n), .frameSync(frameSync)
   );

   // Host access to speeds, positions and frame count
   gameRegs regs
   (
      .clk(clk), .reset_n(reset_n), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
      .wbAdr(wbAdr), .wbDatW(wbDatW), .frameSync(frameSync), .view1(view1),
      .view2(view2), .wbDatR(wbDatR), .wbAck(wbAck), .speed1(speed1), .speed2(speed2)
   );

   gameController #(.tileSize(tileSize)) controller
   (
      .clk(clk), .reset_n(reset_n), .frameSync(frameSync), .pad1(pad1), .pad2(pad2),
      .speed1(speed1), .speed2(speed2), .view1(view1), .view2(view2)
   );

endmodule

// File: sim/gameTb.sv
`timescale 1ns/1ps

module gameTb;

   localparam int tileSize = 32;
   localparam int lineLength = 40;
   localparam int frameLines = 12;
   // One tile in 1/16 pixel
   localparam int tileStep = tileSize * 16;
   localparam int numFrames = 200;
   localparam int eofLimit = 2 * lineLength * frameLines;
   localparam int ackLimit = 16;

   logic                 clk;
   logic                 reset_n;
   gamePkg::padKeys_t    pad1;
   gamePkg::padKeys_t    pad2;
   logic                 wbCyc;
   logic                 wbStb;
   logic                 wbWe;
   logic [2:0]           wbAdr;
   logic [31:0]          wbDatW;
   logic [31:0]          wbDatR;
   logic                 wbAck;
   gamePkg::playerView_t view1;
   gamePkg::playerView_t view2;
   videoPkg::frameSync_t frameSync;

   // Reference state per player with positions in 15-bit fixed point
   logic signed [14:0] mPosX [2];
   logic signed [14:0] mPosY [2];
   logic signed [14:0] mGoalX [2];
   logic signed [14:0] mGoalY [2];
   // Speed taken when the move started
   logic [9:0]         mStride [2];
   logic [9:0]         mSpeed [2];
   bit                 mMoving [2];
   bit                 mPhase [2];
   gamePkg::moveDir_t  mDir [2];
   gamePkg::sprite_t   mSprite [2];

   int eofSeen = 0;
   bit timedOut = 1'b0;
   int testsPassed = 0;
   int testsFailed = 0;
   int resetErr = 0;
   int speedErr = 0;
   int motionErr = 0;
   int spriteErr = 0;
   int readErr = 0;

   gameTop #(.tileSize(tileSize), .lineLength(lineLength), .frameLines(frameLines)) uut
   (
      .clk(clk), .reset_n(reset_n), .pad1(pad1), .pad2(pad2), .wbCyc(wbCyc), .wbStb(wbStb),
      .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
      .view1(view1), .view2(view2), .frameSync(frameSync)
   );

   initial
   begin
      clk = 1'b0;
      forever
         #50 clk = ~clk;
   end

   // Frames seen since reset for the frame counter readback
   always @(negedge clk)
   begin
      if (reset_n && frameSync.eof)
         eofSeen <= eofSeen + 1;
   end

   task automatic logError(input string msg);
      $display("Error at %0t ns: %s", $time, msg);
   endtask

   task automatic reportTest(input string name, input int errs);
      if (errs == 0 && !timedOut)
      begin
         testsPassed++;
         $display("%s: passed", name);
      end
      else
      begin
         testsFailed++;
         $display("%s: failed with %0d errors", name, errs);
      end
   endtask

   // Single Wishbone classic cycle started on a falling edge
   task automatic busAccess(input bit write, input logic [2:0] addr, input logic [31:0] data,
                            output logic [31:0] rdata);
      int cycles;
      rdata = '0;
      if (!timedOut)
      begin
         wbCyc = 1'b1;
         wbStb = 1'b1;
         wbWe = write;
         wbAdr = addr;
         wbDatW = data;
         cycles = 0;
         do
         begin
            @(negedge clk);
            cycles++;
         end
         while (!wbAck && cycles < ackLimit);
         if (wbAck)
            rdata = wbDatR;
         else
         begin
            $display("Timeout: no Wishbone ack after %0d cycles at address %0d", cycles, addr);
            timedOut = 1'b1;
         end
         // Request held over the edge that takes the ack
         @(negedge clk);
         wbCyc = 1'b0;
         wbStb = 1'b0;
         wbWe = 1'b0;
      end
   endtask

   task automatic readReg(input logic [2:0] addr, output logic [31:0] data);
      busAccess(1'b0, addr, 32'd0, data);
   endtask

   task automatic writeSpeed(input int p, input logic [31:0] value);
      logic [31:0] ignored;
      busAccess(1'b1, (p == 0) ? gamePkg::addrSpeed1 : gamePkg::addrSpeed2, value, ignored);
      // A written zero is kept as 1
      mSpeed[p] = (value[9:0] == 10'd0) ? 10'd1 : value[9:0];
   endtask

   task automatic waitForEof;
      int cycles;
      cycles = 0;
      do
      begin
         @(negedge clk);
         cycles++;
      end
      while (!frameSync.eof && cycles < eofLimit);
      if (!frameSync.eof)
      begin
         $display("Timeout: no end of frame within %0d cycles", cycles);
         timedOut = 1'b1;
      end
   endtask

   // Walk frames alternate with frame 1 on a set phase
   function automatic gamePkg::sprite_t expectedSprite(input gamePkg::moveDir_t d,
                                                        input bit mov, input bit ph);
      if (!mov)
         return gamePkg::spriteFace;
      case (d)
         gamePkg::dirUp: return ph ? gamePkg::spriteUp1 : gamePkg::spriteUp2;
         gamePkg::dirRight: return ph ? gamePkg::spriteRight1 : gamePkg::spriteRight2;
         gamePkg::dirLeft: return ph ? gamePkg::spriteLeft1 : gamePkg::spriteLeft2;
         default: return gamePkg::spriteFace;
      endcase
   endfunction

   // One frame step of one player as distance left along the move
   task automatic modelStep(input int p, input gamePkg::padKeys_t keys);
      logic signed [14:0] distLeft;
      logic signed [14:0] stride;
      // Keys only count while standing and up wins over down, right and left
      if (!mMoving[p] && keys != 4'b0)
      begin
         mMoving[p] = 1'b1;
         mStride[p] = mSpeed[p];
         mGoalX[p] = mPosX[p];
         mGoalY[p] = mPosY[p];
         if (keys.up)
         begin
            mDir[p] = gamePkg::dirUp;
            mGoalY[p] = mPosY[p] - 15'(tileStep);
         end
         else if (keys.down)
         begin
            mDir[p] = gamePkg::dirDown;
            mGoalY[p] = mPosY[p] + 15'(tileStep);
         end
         else if (keys.right)
         begin
            mDir[p] = gamePkg::dirRight;
            mGoalX[p] = mPosX[p] + 15'(tileStep);
         end
         else
         begin
            mDir[p] = gamePkg::dirLeft;
            mGoalX[p] = mPosX[p] - 15'(tileStep);
         end
      end
      if (mMoving[p])
      begin
         stride = 15'(mStride[p]);
         case (mDir[p])
            gamePkg::dirUp: distLeft = mPosY[p] - mGoalY[p];
            gamePkg::dirDown: distLeft = mGoalY[p] - mPosY[p];
            gamePkg::dirRight: distLeft = mGoalX[p] - mPosX[p];
            default: distLeft = mPosX[p] - mGoalX[p];
         endcase
         if (stride >= distLeft)
         begin
            // Landing exactly on the tile
            mPosX[p] = mGoalX[p];
            mPosY[p] = mGoalY[p];
            mMoving[p] = 1'b0;
            mDir[p] = gamePkg::dirNone;
         end
         else
         begin
            case (mDir[p])
               gamePkg::dirUp: mPosY[p] = mPosY[p] - stride;
               gamePkg::dirDown: mPosY[p] = mPosY[p] + stride;
               gamePkg::dirRight: mPosX[p] = mPosX[p] + stride;
               default: mPosX[p] = mPosX[p] - stride;
            endcase
         end
      end
      mPhase[p] = mMoving[p] ? !mPhase[p] : 1'b0;
      mSprite[p] = expectedSprite(mDir[p], mMoving[p], mPhase[p]);
   endtask

   task automatic checkViews(output int posErrs, output int spriteErrs);
      gamePkg::playerView_t v;
      int p;
      posErrs = 0;
      spriteErrs = 0;
      for (p = 0; p < 2; p++)
      begin
         v = (p == 0) ? view1 : view2;
         if (v.pos.x != mPosX[p][14:4] || v.pos.y != mPosY[p][14:4])
         begin
            logError($sformatf("player %0d at %0d,%0d, expected %0d,%0d", p + 1, v.pos.x,
                     v.pos.y, $signed(mPosX[p][14:4]), $signed(mPosY[p][14:4])));
            posErrs++;
         end
         if (v.sprite != mSprite[p])
         begin
            logError($sformatf("player %0d sprite %0d, expected %0d", p + 1, v.sprite,
                     mSprite[p]));
            spriteErrs++;
         end
      end
   endtask

   // Bus position words against the model positions
   task automatic checkReadback;
      logic [31:0] data;
      logic [31:0] expected;
      logic [10:0] x;
      logic [10:0] y;
      int p;
      for (p = 0; p < 2; p++)
      begin
         x = mPosX[p][14:4];
         y = mPosY[p][14:4];
         readReg((p == 0) ? gamePkg::addrPos1 : gamePkg::addrPos2, data);
         expected = {{5{x[10]}}, x, {5{y[10]}}, y};
         if (!timedOut && data !== expected)
         begin
            logError($sformatf("position %0d read %h, expected %h", p + 1, data, expected));
            readErr++;
         end
      end
   endtask

   initial
   begin
      logic [31:0] data;
      logic [31:0] value;
      gamePkg::padKeys_t keys1;
      gamePkg::padKeys_t keys2;
      int posErrs;
      int sprErrs;
      int i;
      int p;
      int frame;

      void'($urandom(32'h9a4fe66b));
      reset_n = 1'b0;
      pad1 = '0;
      pad2 = '0;
      wbCyc = 1'b0;
      wbStb = 1'b0;
      wbWe = 1'b0;
      wbAdr = '0;
      wbDatW = '0;

      // Start tiles 128,128 and 448,448 in 1/16 pixel
      mPosX[0] = 15'(128 * 16);
      mPosY[0] = 15'(128 * 16);
      mPosX[1] = 15'(448 * 16);
      mPosY[1] = 15'(448 * 16);
      mSpeed[0] = 10'd16;
      mSpeed[1] = 10'd3;
      for (p = 0; p < 2; p++)
      begin
         mGoalX[p] = '0;
         mGoalY[p] = '0;
         mStride[p] = '0;
         mMoving[p] = 1'b0;
         mPhase[p] = 1'b0;
         mDir[p] = gamePkg::dirNone;
         mSprite[p] = gamePkg::spriteFace;
      end

      repeat (16) @(negedge clk);
      reset_n = 1'b1;
      @(negedge clk);

      // Reset values
      checkViews(posErrs, sprErrs);
      resetErr = posErrs + sprErrs;
      if (wbAck)
      begin
         logError("wbAck high after reset");
         resetErr++;
      end
      readReg(gamePkg::addrSpeed1, data);
      if (!timedOut && data !== 32'd16)
      begin
         logError($sformatf("speed 1 after reset %0d, expected 16", data));
         resetErr++;
      end
      readReg(gamePkg::addrSpeed2, data);
      if (!timedOut && data !== 32'd3)
      begin
         logError($sformatf("speed 2 after reset %0d, expected 3", data));
         resetErr++;
      end
      reportTest("reset", resetErr);

      // Random speed writes with a zero low part in every other pair
      for (i = 0; i < 12; i++)
      begin
         p = i % 2;
         value = $urandom;
         if (i % 4 >= 2)
            value[9:0] = '0;
         writeSpeed(p, value);
         readReg((p == 0) ? gamePkg::addrSpeed1 : gamePkg::addrSpeed2, data);
         if (!timedOut && data !== 32'(mSpeed[p]))
         begin
            logError($sformatf("speed %0d read %0d, expected %0d", p + 1, data, mSpeed[p]));
            speedErr++;
         end
      end
      writeSpeed(0, $urandom_range(8, 48));
      writeSpeed(1, $urandom_range(8, 48));
      reportTest("speed registers", speedErr);

      // Positions and sprites are checked at each sof
      for (frame = 0; frame < numFrames && !timedOut; frame++)
      begin
         waitForEof();
         if (!timedOut)
         begin
            @(negedge clk);
            if (!frameSync.sof)
            begin
               logError("no start of frame right after end of frame");
               motionErr++;
            end
            checkViews(posErrs, sprErrs);
            motionErr += posErrs;
            spriteErr += sprErrs;
            // Pads for the steps of this frame
            keys1 = 4'($urandom);
            keys2 = 4'($urandom);
            pad1 = keys1;
            pad2 = keys2;
            modelStep(0, keys1);
            modelStep(1, keys2);
            // Both steps are done within 5 clocks of eof
            repeat (5) @(negedge clk);
            if ($urandom_range(0, 15) == 0)
            begin
               p = $urandom_range(0, 1);
               if ($urandom_range(0, 7) == 0)
                  writeSpeed(p, $urandom_range(0, 1023));
               else
                  writeSpeed(p, $urandom_range(1, 96));
            end
            checkReadback();
         end
      end
      checkViews(posErrs, sprErrs);
      motionErr += posErrs;
      spriteErr += sprErrs;
      reportTest("motion", motionErr);
      reportTest("sprites", spriteErr);

      readReg(gamePkg::addrFrames, data);
      if (!timedOut && data !== 32'(eofSeen))
      begin
         logError($sformatf("frame count %0d, expected %0d", data, eofSeen));
         readErr++;
      end
      reportTest("readback", readErr);

      $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
      if (timedOut || testsFailed != 0)
         $display("sim failed");
      else
         $display("sim passed");
      $finish;
   end

endmodule

// File: filelist.f
verilog/gamePkg.sv
verilog/videoPkg.sv
verilog/frameTimer.sv
verilog/playerMotion.sv
verilog/spriteAnimator.sv
verilog/gameController.sv
verilog/gameRegs.sv
verilog/gameTop.sv
sim/gameTb.sv

// File: run.sh
#!/bin/sh
# Build the game testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
   --top-module gameTb -f filelist.f -o gameSim
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$(./obj_dir/gameSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

# The run passes only if the testbench printed its pass line
if echo "$output" | grep -qx "sim passed"; then
   exit 0
fi
exit 1
